//--- source/vec_defs.svh
// Build constants of the vector co-processor
// VEC_NR_LANES must be a power of two and at least 1
// VEC_VLMAX must be a multiple of VEC_NR_LANES
// VEC_ELEMS_PER_LANE must be 2 or more, so that a lane slot index has at least one bit
// Nothing here is checked at elaboration, so keep these rules when editing
`ifndef VEC_DEFS_SVH
`define VEC_DEFS_SVH

// Number of parallel lanes
`define VEC_NR_LANES 4

// Element and scalar width in bits
`define VEC_ELEN 32

// Architectural vector registers
`define VEC_NR_VREGS 32

// Elements per vector register
`define VEC_VLMAX 8

// Elements of one register held by each lane
`define VEC_ELEMS_PER_LANE (`VEC_VLMAX / `VEC_NR_LANES)

`endif

//--- source/vec_pkg.sv
// Shared types of the vector co-processor
// Widths follow the constants in vec_defs.svh
// Opcodes 10 to 15 have no enum value and get an error response
`default_nettype none

`include "vec_defs.svh"

package vec_pkg;

  ////////////////////////////////////////////////////////////////////
  // Plain widths
  ////////////////////////////////////////////////////////////////////

  typedef logic [`VEC_ELEN-1:0]                   elen_t;
  typedef logic [$clog2(`VEC_NR_VREGS)-1:0]       vreg_idx_t;
  typedef logic [$clog2(`VEC_VLMAX+1)-1:0]        vlen_t;
  typedef logic [$clog2(`VEC_ELEMS_PER_LANE)-1:0] elem_idx_t;
  typedef logic [3:0]                             opcode_t;

  // Legal operations, encoded as on the request port
  typedef enum opcode_t {
    VSETVL  = 4'd0,
    VADD_VV = 4'd1,
    VADD_VX = 4'd2,
    VSUB_VV = 4'd3,
    VAND_VV = 4'd4,
    VOR_VV  = 4'd5,
    VXOR_VV = 4'd6,
    VMV_VX  = 4'd7,
    VID     = 4'd8,
    VEXT_XV = 4'd9
  } vec_op_e;

  ////////////////////////////////////////////////////////////////////
  // Port bundles
  ////////////////////////////////////////////////////////////////////

  // Request from the scalar core
  typedef struct packed {
    opcode_t   opcode;
    vreg_idx_t vs1;
    vreg_idx_t vs2;
    vreg_idx_t vd;
    elen_t     scalar;
  } acc_req_t;

  // Response to the scalar core
  typedef struct packed {
    elen_t data;
    logic  error;
  } acc_resp_t;

  // Decoded request with the current vl attached
  typedef struct packed {
    vec_op_e   op;
    vreg_idx_t vs1;
    vreg_idx_t vs2;
    vreg_idx_t vd;
    elen_t     scalar;
    vlen_t     vl;
  } vec_req_t;

  // Broadcast from the sequencer to every lane
  typedef struct packed {
    vec_op_e   op;
    vreg_idx_t vs1;
    vreg_idx_t vs2;
    vreg_idx_t vd;
    elen_t     scalar;
    vlen_t     vl;
  } lane_req_t;

  // Enum literals carry a prefix since both FSMs share this scope
  typedef enum logic [1:0] {
    DISP_IDLE,
    DISP_SEND,
    DISP_WAIT_RESP
  } disp_state_e;

  typedef enum logic [1:0] {
    SEQ_IDLE,
    SEQ_RUN,
    SEQ_RESP
  } seq_state_e;

endpackage : vec_pkg

`default_nettype wire

//--- source/vec_dispatcher.sv
// Request stage of the vector co-processor
// Only one request is accepted at a time
// acc_req_ready_o stays low until the response of that request
// The core must take every response pulse since there is no back-pressure
// VSETVL and illegal opcodes never reach the sequencer
`timescale 1ns/1ns
`default_nettype none

`include "vec_defs.svh"

module vec_dispatcher import vec_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  // Core side
  input  acc_req_t  acc_req_i,
  input  logic      acc_req_valid_i,
  output logic      acc_req_ready_o,
  output acc_resp_t acc_resp_o,
  output logic      acc_resp_valid_o,
  // Sequencer side
  output vec_req_t  seq_req_o,
  output logic      seq_req_valid_o,
  input  logic      seq_req_ready_i,
  input  elen_t     seq_resp_i,
  input  logic      seq_resp_valid_i
);

  disp_state_e state_q;
  disp_state_e state_d;
  logic        ready_q;
  acc_req_t    req_q;
  vlen_t       vl_q;
  vlen_t       vl_d;
  vlen_t       setvl_vl;
  vec_op_e     dec_op;
  logic        illegal_op;
  logic        acc_accept;

  assign acc_req_ready_o = ready_q;
  assign acc_accept      = acc_req_valid_i & ready_q;

  // Decode of the buffered request
  assign illegal_op = (req_q.opcode > opcode_t'(VEXT_XV));
  assign dec_op     = vec_op_e'(req_q.opcode);

  // Requested length clamped to VLMAX
  assign setvl_vl = (req_q.scalar >= elen_t'(`VEC_VLMAX)) ? vlen_t'(`VEC_VLMAX)
                                                          : vlen_t'(req_q.scalar);

  always_comb begin
    seq_req_o.op     = dec_op;
    seq_req_o.vs1    = req_q.vs1;
    seq_req_o.vs2    = req_q.vs2;
    seq_req_o.vd     = req_q.vd;
    seq_req_o.scalar = req_q.scalar;
    seq_req_o.vl     = vl_q;
  end

  ////////////////////////////////////////////////////////////////////
  // FSM and response merge
  ////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d          = state_q;
    vl_d             = vl_q;
    seq_req_valid_o  = 1'b0;
    acc_resp_valid_o = 1'b0;
    acc_resp_o       = '0;
    case (state_q)
      DISP_IDLE: begin
        if (acc_accept) begin
          state_d = DISP_SEND;
        end
      end
      DISP_SEND: begin
        if (illegal_op) begin
          // Error with zero data, no state touched
          acc_resp_valid_o = 1'b1;
          acc_resp_o.error = 1'b1;
          state_d          = DISP_IDLE;
        end else if (dec_op == VSETVL) begin
          acc_resp_valid_o = 1'b1;
          acc_resp_o.data  = elen_t'(setvl_vl);
          vl_d             = setvl_vl;
          state_d          = DISP_IDLE;
        end else begin
          seq_req_valid_o = 1'b1;
          if (seq_req_ready_i) begin
            state_d = DISP_WAIT_RESP;
          end
        end
      end
      DISP_WAIT_RESP: begin
        if (seq_resp_valid_i) begin
          acc_resp_valid_o = 1'b1;
          acc_resp_o.data  = seq_resp_i;
          state_d          = DISP_IDLE;
        end
      end
      default: state_d = DISP_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= DISP_IDLE;
      ready_q <= 1'b0;
      vl_q    <= vlen_t'(`VEC_VLMAX);
    end else begin
      state_q <= state_d;
      // Ready again once the FSM returns to idle
      ready_q <= (state_d == DISP_IDLE);
      vl_q    <= vl_d;
    end
  end

  // Request buffer
  always_ff @(posedge clk_i) begin
    if (acc_accept) begin
      req_q <= acc_req_i;
    end
  end

endmodule : vec_dispatcher

`default_nettype wire

//--- source/vec_sequencer.sv
// Issue stage of the vector co-processor
// Runs one vector instruction at a time, so no hazard tracking is needed
// Relies on all lanes finishing in the same cycle and watches lane 0 only
// An out-of-range VEXT_XV index returns 0 since no lane claims it
`timescale 1ns/1ns
`default_nettype none

`include "vec_defs.svh"

module vec_sequencer import vec_pkg::*; (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  // Dispatcher side
  input  vec_req_t                   seq_req_i,
  input  logic                       seq_req_valid_i,
  output logic                       seq_req_ready_o,
  output elen_t                      seq_resp_o,
  output logic                       seq_resp_valid_o,
  // Lane side
  output lane_req_t                  lane_req_o,
  output logic                       lane_req_valid_o,
  input  logic  [`VEC_NR_LANES-1:0]  lane_done_i,
  input  elen_t [`VEC_NR_LANES-1:0]  lane_scalar_i,
  input  logic  [`VEC_NR_LANES-1:0]  lane_scalar_valid_i
);

  seq_state_e state_q;
  seq_state_e state_d;
  lane_req_t  insn_q;
  logic       issue_q;
  elen_t      scalar_q;
  elen_t      scalar_d;
  logic       seq_accept;

  assign seq_req_ready_o = (state_q == SEQ_IDLE);
  assign seq_accept      = seq_req_valid_i & seq_req_ready_o;

  assign lane_req_o       = insn_q;
  assign lane_req_valid_o = issue_q;

  // Only VEXT_XV returns data
  assign seq_resp_valid_o = (state_q == SEQ_RESP);
  assign seq_resp_o       = (insn_q.op == VEXT_XV) ? scalar_q : '0;

  ////////////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      SEQ_IDLE: begin
        if (seq_accept) begin
          state_d = SEQ_RUN;
        end
      end
      SEQ_RUN: begin
        if (lane_done_i[0]) begin
          state_d = SEQ_RESP;
        end
      end
      SEQ_RESP: state_d = SEQ_IDLE;
      default:  state_d = SEQ_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= SEQ_IDLE;
      issue_q <= 1'b0;
    end else begin
      state_q <= state_d;
      // Broadcast pulse one cycle after acceptance
      issue_q <= seq_accept;
    end
  end

  // Scalar from whichever lane owns the index
  always_comb begin
    scalar_d = scalar_q;
    for (int i = 0; i < `VEC_NR_LANES; i++) begin
      if (lane_scalar_valid_i[i]) begin
        scalar_d = lane_scalar_i[i];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (seq_accept) begin
      insn_q.op     <= seq_req_i.op;
      insn_q.vs1    <= seq_req_i.vs1;
      insn_q.vs2    <= seq_req_i.vs2;
      insn_q.vd     <= seq_req_i.vd;
      insn_q.scalar <= seq_req_i.scalar;
      insn_q.vl     <= seq_req_i.vl;
      scalar_q      <= '0;
    end else begin
      scalar_q <= scalar_d;
    end
  end

endmodule : vec_sequencer

`default_nettype wire

//--- source/vec_lane.sv
// One lane of the vector co-processor
// Holds VEC_ELEMS_PER_LANE elements of every vector register
// Local slot k maps to global element k * VEC_NR_LANES + LaneId
// Reads and write-backs overlap, so element k+1 is read while k is written
// A new lane request must not arrive before lane_done_o of the previous one
`timescale 1ns/1ns
`default_nettype none

`include "vec_defs.svh"

module vec_lane import vec_pkg::*; #(
  parameter int unsigned LaneId = 0
) (
  input  logic      clk_i,
  input  logic      rst_n_i,
  // Sequencer side
  input  lane_req_t lane_req_i,
  input  logic      lane_req_valid_i,
  output logic      lane_done_o,
  output elen_t     lane_scalar_o,
  output logic      lane_scalar_valid_o
);

  localparam elem_idx_t LastSlot = elem_idx_t'(`VEC_ELEMS_PER_LANE - 1);

  // VRF slice
  elen_t     vrf_q [`VEC_NR_VREGS][`VEC_ELEMS_PER_LANE];

  lane_req_t req_q;
  logic      rd_active_q;
  elem_idx_t rd_idx_q;
  logic      s1_valid_q;
  elem_idx_t s1_idx_q;
  elen_t     s1_a_q;
  elen_t     s1_b_q;
  logic      done_q;
  elen_t     gidx;
  elen_t     result;
  logic      writes_vd;
  logic      wr_en;

  // Global element number of the slot in stage two
  assign gidx = elen_t'(s1_idx_q) * `VEC_NR_LANES + LaneId;

  assign writes_vd = (req_q.op != VEXT_XV) && (req_q.op != VSETVL);
  // Tail elements at or above vl stay untouched
  assign wr_en     = s1_valid_q && writes_vd && (gidx < elen_t'(req_q.vl));

  // Extract ignores vl and fires only in the owning lane
  assign lane_scalar_valid_o = s1_valid_q && (req_q.op == VEXT_XV) && (gidx == req_q.scalar);
  assign lane_scalar_o       = s1_b_q;
  assign lane_done_o         = done_q;

  ////////////////////////////////////////////////////////////////////
  // Stage two ALU
  ////////////////////////////////////////////////////////////////////

  always_comb begin
    case (req_q.op)
      VADD_VV: result = s1_b_q + s1_a_q;
      VADD_VX: result = s1_b_q + req_q.scalar;
      // vd = vs2 - vs1
      VSUB_VV: result = s1_b_q - s1_a_q;
      VAND_VV: result = s1_b_q & s1_a_q;
      VOR_VV:  result = s1_b_q | s1_a_q;
      VXOR_VV: result = s1_b_q ^ s1_a_q;
      VMV_VX:  result = req_q.scalar;
      VID:     result = gidx;
      default: result = s1_b_q;
    endcase
  end

  ////////////////////////////////////////////////////////////////////
  // Control, VRF and stage one
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rd_active_q <= 1'b0;
      rd_idx_q    <= '0;
      s1_valid_q  <= 1'b0;
      done_q      <= 1'b0;
      for (int r = 0; r < `VEC_NR_VREGS; r++) begin
        for (int e = 0; e < `VEC_ELEMS_PER_LANE; e++) begin
          vrf_q[r][e] <= '0;
        end
      end
    end else begin
      if (lane_req_valid_i) begin
        rd_active_q <= 1'b1;
        rd_idx_q    <= '0;
      end else if (rd_active_q) begin
        rd_idx_q <= rd_idx_q + 1'b1;
        if (rd_idx_q == LastSlot) begin
          rd_active_q <= 1'b0;
        end
      end
      s1_valid_q <= rd_active_q;
      // Done one cycle after the last write-back
      done_q     <= s1_valid_q && (s1_idx_q == LastSlot);
      if (wr_en) begin
        vrf_q[req_q.vd][s1_idx_q] <= result;
      end
    end
  end

  // Instruction and operand registers
  always_ff @(posedge clk_i) begin
    if (lane_req_valid_i) begin
      req_q <= lane_req_i;
    end
    s1_idx_q <= rd_idx_q;
    s1_a_q   <= vrf_q[req_q.vs1][rd_idx_q];
    s1_b_q   <= vrf_q[req_q.vs2][rd_idx_q];
  end

endmodule : vec_lane

`default_nettype wire

//--- source/vec_top.sv
// Top level of the vector co-processor
// Dispatcher, sequencer and VEC_NR_LANES lanes
// One request in flight and exactly one response per request, in order
`timescale 1ns/1ns
`default_nettype none

`include "vec_defs.svh"

module vec_top import vec_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  acc_req_t  acc_req_i,
  input  logic      acc_req_valid_i,
  output logic      acc_req_ready_o,
  output acc_resp_t acc_resp_o,
  output logic      acc_resp_valid_o
);

  // Dispatcher to sequencer
  vec_req_t                         seq_req;
  logic                             seq_req_valid;
  logic                             seq_req_ready;
  elen_t                            seq_resp;
  logic                             seq_resp_valid;

  // Sequencer to lanes
  lane_req_t                        lane_req;
  logic                             lane_req_valid;
  logic      [`VEC_NR_LANES-1:0]    lane_done;
  elen_t     [`VEC_NR_LANES-1:0]    lane_scalar;
  logic      [`VEC_NR_LANES-1:0]    lane_scalar_valid;

  vec_dispatcher u_dispatcher (
    .clk_i            (clk_i           ),
    .rst_n_i          (rst_n_i         ),
    .acc_req_i        (acc_req_i       ),
    .acc_req_valid_i  (acc_req_valid_i ),
    .acc_req_ready_o  (acc_req_ready_o ),
    .acc_resp_o       (acc_resp_o      ),
    .acc_resp_valid_o (acc_resp_valid_o),
    .seq_req_o        (seq_req         ),
    .seq_req_valid_o  (seq_req_valid   ),
    .seq_req_ready_i  (seq_req_ready   ),
    .seq_resp_i       (seq_resp        ),
    .seq_resp_valid_i (seq_resp_valid  )
  );

  vec_sequencer u_sequencer (
    .clk_i               (clk_i            ),
    .rst_n_i             (rst_n_i          ),
    .seq_req_i           (seq_req          ),
    .seq_req_valid_i     (seq_req_valid    ),
    .seq_req_ready_o     (seq_req_ready    ),
    .seq_resp_o          (seq_resp         ),
    .seq_resp_valid_o    (seq_resp_valid   ),
    .lane_req_o          (lane_req         ),
    .lane_req_valid_o    (lane_req_valid   ),
    .lane_done_i         (lane_done        ),
    .lane_scalar_i       (lane_scalar      ),
    .lane_scalar_valid_i (lane_scalar_valid)
  );

  for (genvar lane = 0; lane < `VEC_NR_LANES; lane++) begin : gen_lanes
    vec_lane #(
      .LaneId (lane)
    ) u_lane (
      .clk_i               (clk_i                  ),
      .rst_n_i             (rst_n_i                ),
      .lane_req_i          (lane_req               ),
      .lane_req_valid_i    (lane_req_valid         ),
      .lane_done_o         (lane_done[lane]        ),
      .lane_scalar_o       (lane_scalar[lane]      ),
      .lane_scalar_valid_o (lane_scalar_valid[lane])
    );
  end : gen_lanes

endmodule : vec_top

`default_nettype wire

//--- tests/vec_top_assert.sv
// Concurrent checks on the top level of the vector co-processor
// Assumes every lane finishes in the same cycle
// Only one lane may own a VEXT_XV index
`timescale 1ns/1ns
`default_nettype none

`include "vec_defs.svh"

module vec_top_assert import vec_pkg::*; (
  input logic                     clk_i,
  input logic                     rst_n_i,
  input logic                     acc_req_ready_i,
  input acc_resp_t                acc_resp_i,
  input logic                     acc_resp_valid_i,
  input logic [`VEC_NR_LANES-1:0] lane_done_i,
  input logic [`VEC_NR_LANES-1:0] lane_scalar_valid_i
);

  int unsigned assert_fail_count = 0;

  ////////////////////////////////////////////////////////////////////
  // Properties
  ////////////////////////////////////////////////////////////////////

  resp_known: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    acc_resp_valid_i |-> !$isunknown(acc_resp_i))
    else begin
      assert_fail_count = assert_fail_count + 1;
      $error("acc_resp_o carries unknown bits while valid");
    end

  // Lanes run in lockstep
  lanes_done_together: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (&lane_done_i) || !(|lane_done_i))
    else begin
      assert_fail_count = assert_fail_count + 1;
      $error("lane_done bits differ between lanes");
    end

  single_scalar_owner: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0(lane_scalar_valid_i))
    else begin
      assert_fail_count = assert_fail_count + 1;
      $error("more than one lane drives a scalar");
    end

  // First reset edge loads ready_q, so check from the second one on
  no_ready_in_reset: assert property (@(posedge clk_i)
    (!rst_n_i && !$past(rst_n_i)) |-> !acc_req_ready_i)
    else begin
      assert_fail_count = assert_fail_count + 1;
      $error("acc_req_ready_o high during reset");
    end

endmodule : vec_top_assert

bind vec_top vec_top_assert u_assert (
  .clk_i               (clk_i            ),
  .rst_n_i             (rst_n_i          ),
  .acc_req_ready_i     (acc_req_ready_o  ),
  .acc_resp_i          (acc_resp_o       ),
  .acc_resp_valid_i    (acc_resp_valid_o ),
  .lane_done_i         (lane_done        ),
  .lane_scalar_valid_i (lane_scalar_valid)
);

`default_nettype wire

//--- tests/tb_vec_top.sv
// Testbench of the vector co-processor
// Expects the assertion module bound into vec_top as u_assert
// Requests go out one at a time and responses are checked in order
// Run length is bounded by a watchdog of 40 cycles per request
`timescale 1ns/1ns
`default_nettype none

`include "vec_defs.svh"

module tb_vec_top import vec_pkg::*; ();

  localparam int RESET_CYCLES = 10;
  localparam int VLMAX        = `VEC_VLMAX;
  localparam int N_RAND_SETVL = 4;
  localparam int N_SPLAT_REGS = 4;
  localparam int N_VID_RUNS   = 3;
  localparam int N_ALU_ITERS  = 20;
  localparam int N_ILLEGAL    = 6;
  localparam int N_MIX        = 200;
  localparam int DRAIN_CYCLES = 20;
  localparam int NUM_REQS     = (3 + N_RAND_SETVL)
                              + (1 + N_SPLAT_REGS + N_SPLAT_REGS * (VLMAX + 3))
                              + N_VID_RUNS * (2 + VLMAX)
                              + N_ALU_ITERS * (2 + VLMAX)
                              + (N_ILLEGAL * (1 + VLMAX) + 1 + VLMAX)
                              + N_MIX;
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + 40 * NUM_REQS;

  logic      clk_i           = 1'b0;
  logic      rst_n_i         = 1'b0;
  acc_req_t  acc_req_i       = '0;
  logic      acc_req_valid_i = 1'b0;
  logic      acc_req_ready_o;
  acc_resp_t acc_resp_o;
  logic      acc_resp_valid_o;

  // Reference state
  elen_t     model_vrf [`VEC_NR_VREGS][`VEC_VLMAX];
  int        model_vl;
  acc_resp_t exp_q [$];

  // Set on a transfer, cleared by its response
  logic req_pending = 1'b0;

  int issued_count    = 0;
  int resp_count      = 0;
  int data_errors     = 0;
  int flag_errors     = 0;
  int protocol_errors = 0;

  vec_top u_dut (
    .clk_i            (clk_i           ),
    .rst_n_i          (rst_n_i         ),
    .acc_req_i        (acc_req_i       ),
    .acc_req_valid_i  (acc_req_valid_i ),
    .acc_req_ready_o  (acc_req_ready_o ),
    .acc_resp_o       (acc_resp_o      ),
    .acc_resp_valid_o (acc_resp_valid_o)
  );

  initial begin
    forever #50 clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////

  function automatic acc_resp_t predict_response(input acc_req_t req);
    acc_resp_t resp;
    vec_op_e   op;
    elen_t     a;
    elen_t     b;
    elen_t     r;
    resp = '0;
    op   = vec_op_e'(req.opcode);
    if (req.opcode > 4'd9) begin
      resp.error = 1'b1;
    end else if (op == VSETVL) begin
      model_vl  = (req.scalar >= VLMAX) ? VLMAX : int'(req.scalar);
      resp.data = elen_t'(model_vl);
    end else if (op == VEXT_XV) begin
      // Index beyond VLMAX reads as zero, vl is ignored
      if (req.scalar < VLMAX) begin
        resp.data = model_vrf[req.vs2][int'(req.scalar)];
      end
    end else begin
      for (int i = 0; i < model_vl; i++) begin
        a = model_vrf[req.vs1][i];
        b = model_vrf[req.vs2][i];
        case (op)
          VADD_VV: r = b + a;
          VADD_VX: r = b + req.scalar;
          VSUB_VV: r = b - a;
          VAND_VV: r = b & a;
          VOR_VV:  r = b | a;
          VXOR_VV: r = b ^ a;
          VMV_VX:  r = req.scalar;
          VID:     r = elen_t'(i);
          default: r = b;
        endcase
        model_vrf[req.vd][i] = r;
      end
    end
    return resp;
  endfunction

  ////////////////////////////////////////////////////////////////////
  // Request helpers
  ////////////////////////////////////////////////////////////////////

  function automatic acc_req_t build_req(input opcode_t opcode, input vreg_idx_t vs1,
                                         input vreg_idx_t vs2, input vreg_idx_t vd,
                                         input elen_t scalar);
    acc_req_t req;
    req.opcode = opcode;
    req.vs1    = vs1;
    req.vs2    = vs2;
    req.vd     = vd;
    req.scalar = scalar;
    return req;
  endfunction

  function automatic vreg_idx_t rand_vreg(input int unsigned span);
    return vreg_idx_t'($urandom % span);
  endfunction

  // Hold valid until ready is seen, the transfer is on the next rising edge
  task automatic send_request(input acc_req_t req);
    @(posedge clk_i);
    acc_req_i       <= req;
    acc_req_valid_i <= 1'b1;
    @(negedge clk_i);
    while (!acc_req_ready_o) begin
      @(negedge clk_i);
    end
    exp_q.push_back(predict_response(req));
    issued_count++;
    @(posedge clk_i);
    acc_req_valid_i <= 1'b0;
  endtask

  task automatic set_vl(input elen_t n);
    send_request(build_req(VSETVL, '0, '0, '0, n));
  endtask

  task automatic read_element(input vreg_idx_t vs2, input elen_t idx);
    send_request(build_req(VEXT_XV, '0, vs2, '0, idx));
  endtask

  task automatic read_register(input vreg_idx_t vs2);
    for (int i = 0; i < VLMAX; i++) begin
      read_element(vs2, elen_t'(i));
    end
  endtask

  ////////////////////////////////////////////////////////////////////
  // Test sequences
  ////////////////////////////////////////////////////////////////////

  task automatic clamp_vl_sweep();
    set_vl(0);
    set_vl(5);
    set_vl(elen_t'(VLMAX));
    for (int k = 0; k < N_RAND_SETVL; k++) begin
      set_vl($urandom | 32'h10);
    end
  endtask

  task automatic splat_and_extract();
    set_vl(elen_t'(VLMAX));
    for (int r = 0; r < N_SPLAT_REGS; r++) begin
      send_request(build_req(VMV_VX, '0, '0, vreg_idx_t'(r), $urandom));
    end
    // Two indexes past the end and one far out of range
    for (int r = 0; r < N_SPLAT_REGS; r++) begin
      for (int i = 0; i < VLMAX + 2; i++) begin
        read_element(vreg_idx_t'(r), elen_t'(i));
      end
      read_element(vreg_idx_t'(r), $urandom | 32'h100);
    end
  endtask

  task automatic vid_readback();
    int vls [N_VID_RUNS];
    vls = '{VLMAX, 5, 3};
    for (int k = 0; k < N_VID_RUNS; k++) begin
      set_vl(elen_t'(vls[k]));
      send_request(build_req(VID, '0, '0, vreg_idx_t'(4 + k), '0));
      read_register(vreg_idx_t'(4 + k));
    end
  endtask

  task automatic alu_random_ops();
    vec_op_e   alu_ops [6];
    vreg_idx_t vd;
    alu_ops = '{VADD_VV, VADD_VX, VSUB_VV, VAND_VV, VOR_VV, VXOR_VV};
    for (int n = 0; n < N_ALU_ITERS; n++) begin
      vd = rand_vreg(8);
      set_vl($urandom % (VLMAX + 1));
      send_request(build_req(alu_ops[$urandom % 6], rand_vreg(8), rand_vreg(8), vd, $urandom));
      read_register(vd);
    end
  endtask

  task automatic illegal_opcode_sweep();
    vreg_idx_t touched [N_ILLEGAL];
    for (int k = 0; k < N_ILLEGAL; k++) begin
      touched[k] = rand_vreg(8);
      send_request(build_req(opcode_t'(10 + k), rand_vreg(32), rand_vreg(32), touched[k],
                             $urandom % 12));
    end
    for (int k = 0; k < N_ILLEGAL; k++) begin
      read_register(touched[k]);
    end
    // Splat range shows whether vl moved
    send_request(build_req(VMV_VX, '0, '0, 5'd7, $urandom));
    read_register(5'd7);
  endtask

  task automatic random_mix();
    opcode_t opcode;
    elen_t   scalar;
    for (int n = 0; n < N_MIX; n++) begin
      opcode = opcode_t'($urandom % 16);
      if (opcode == VSETVL) begin
        scalar = $urandom % 12;
      end else if (opcode == VEXT_XV) begin
        scalar = $urandom % 10;
      end else begin
        scalar = $urandom;
      end
      send_request(build_req(opcode, rand_vreg(32), rand_vreg(32), rand_vreg(32), scalar));
    end
  endtask

  ////////////////////////////////////////////////////////////////////
  // Checking
  ////////////////////////////////////////////////////////////////////

  task automatic check_data(input string name, input elen_t expected, input elen_t actual);
    if (actual !== expected) begin
      data_errors++;
      $display("CHECK FAILED at %0t ns: %s expected %h got %h", $time, name, expected, actual);
    end
  endtask

  task automatic check_error(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      flag_errors++;
      $display("CHECK FAILED at %0t ns: %s expected %b got %b", $time, name, expected, actual);
    end
  endtask

  // Transfer seen at the rising edge
  initial begin
    forever begin
      @(posedge clk_i);
      if (rst_n_i && acc_req_valid_i && acc_req_ready_o) begin
        req_pending = 1'b1;
      end
    end
  end

  initial begin
    acc_resp_t expected;
    forever begin
      @(negedge clk_i);
      if (rst_n_i && req_pending && acc_req_ready_o) begin
        protocol_errors++;
        $display("acc_req_ready_o high at %0t ns while a request awaits its response", $time);
      end
      if (rst_n_i && acc_resp_valid_o) begin
        resp_count++;
        req_pending = 1'b0;
        if (exp_q.size() == 0) begin
          protocol_errors++;
          $display("Response at %0t ns arrived with no request outstanding", $time);
        end else begin
          expected = exp_q.pop_front();
          check_data("acc_resp_o.data", expected.data, acc_resp_o.data);
          check_error("acc_resp_o.error", expected.error, acc_resp_o.error);
        end
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("timeout: no response within %0d cycles", WATCHDOG_CYCLES);
    $display("Regression failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////

  initial begin
    int total;
    void'($urandom(32'h9ff55201));
    model_vl = VLMAX;
    for (int r = 0; r < `VEC_NR_VREGS; r++) begin
      for (int e = 0; e < VLMAX; e++) begin
        model_vrf[r][e] = '0;
      end
    end
    repeat (RESET_CYCLES) @(posedge clk_i);
    rst_n_i <= 1'b1;

    clamp_vl_sweep();
    splat_and_extract();
    vid_readback();
    alu_random_ops();
    illegal_opcode_sweep();
    random_mix();

    while (resp_count < issued_count) begin
      @(negedge clk_i);
    end
    // Catch stray responses after the last one
    repeat (DRAIN_CYCLES) @(negedge clk_i);
    if (resp_count != issued_count) begin
      protocol_errors++;
      $display("Sent %0d requests but saw %0d responses", issued_count, resp_count);
    end

    total = data_errors + flag_errors + protocol_errors
          + int'(u_dut.u_assert.assert_fail_count);
    $display("Requests %0d, data errors %0d, error flag errors %0d, protocol errors %0d, %s %0d",
             issued_count, data_errors, flag_errors, protocol_errors, "assertion failures",
             u_dut.u_assert.assert_fail_count);
    if (total == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule : tb_vec_top

`default_nettype wire

//--- verilog.f
+incdir+source
source/vec_pkg.sv
source/vec_dispatcher.sv
source/vec_sequencer.sv
source/vec_lane.sv
source/vec_top.sv
tests/vec_top_assert.sv
tests/tb_vec_top.sv

//--- run.sh
#!/bin/sh
# Build with Verilator, run the regression and judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_vec_top -f verilog.f -o tb_vec_top \
  || { echo "Build failed"; exit 1; }
./obj_dir/tb_vec_top > sim.log 2>&1 || echo "Simulator exited with an error status"
cat sim.log
grep -qx "Regression passed" sim.log && exit 0 || exit 1
